// File: tests/mc_bridge_input.txt
# name type(rd/wr) size(1/2/4) addr data | exp x y mesh_addr mask | return_data group
# hex: addr data x y mesh_addr mask return_data, decimal: size group
tile_ld_w      rd 4 0048048c 00000000 2 1 0123 0 cafe0001 0
tile_st_w      wr 4 00c00040 11223344 0 3 0010 f dead0002 0
tile_ld_edge   rd 4 000ffffc 00000000 3 0 ffff 0 cafe0003 0
tile_st_h2     wr 2 00842816 aabbccdd 1 2 0a05 c dead0004 0
tile_ld_b1     rd 1 43fc48d1 00000000 f f 1234 0 cafe0005 1
dram_ld_bank0  rd 4 80000000 00000000 0 0 0000 0 cafe0006 1
dram_st_bank5  wr 4 8000155c 55667788 1 5 00ab f dead0007 1
dram_ld_bank3  rd 4 80101fb4 00000000 3 0 00fd 0 cafe0008 2
dram_st_bank7  wr 1 800000fb 000000ee 3 5 0006 8 dead0009 2
dram_ld_bank4  rd 2 80000ac2 00000000 0 5 0054 0 cafe000a 2
st_b0          wr 1 00480480 000000a1 2 1 0120 1 dead000b 3
st_b1          wr 1 00480481 0000a200 2 1 0120 2 dead000c 3
st_b2          wr 1 00480482 00a30000 2 1 0120 4 dead000d 3
st_h0          wr 2 00480484 0000b4b4 2 1 0121 3 dead000e 3
ld_h2          rd 2 00480486 00000000 2 1 0121 0 cafe000f 4
ld_b1          rd 1 00480489 00000000 2 1 0122 0 cafe0010 4
st_w_hi        wr 4 0048048c 99aabbcc 2 1 0123 f dead0011 4
ld_b3          rd 1 0048048f 00000000 2 1 0123 0 cafe0012 4
st_h1          wr 2 00480485 00c5c500 2 1 0121 6 dead0013 5
dram_ld_bank7  rd 4 8000007c 00000000 3 5 0003 0 cafe0014 6

// File: sim.f
source/mc_bridge_pkg.sv
source/mc_bridge_cmd_fifo.sv
source/mc_bridge_addr_xlate.sv
source/mc_bridge_packet_build.sv
source/mc_bridge_reorder.sv
source/mc_bridge_top.sv
tests/mc_bridge_asserts.sv
tests/mc_bridge_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = mc_bridge_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
PASS_MSG  = test passed

SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: tests/mc_bridge_tb.sv
`timescale 1ns/1ps

module mc_bridge_tb
  import mc_bridge_pkg::*;
();

  // one command line of the input file
  typedef struct packed {
    cmd_msg_s             cmd;
    logic [CORD_W-1:0]    x;
    logic [CORD_W-1:0]    y;
    logic [MC_ADDR_W-1:0] maddr;
    logic [MASK_W-1:0]    mask;
    logic [DATA_W-1:0]    ret_data;
    logic [7:0]           group;
  } vec_s;

  logic              clk_i;
  logic              arst_n_i;
  cmd_msg_s          cmd_i;
  logic              cmd_valid_i;
  logic              cmd_ready_o;
  cmd_msg_s          resp_o;
  logic              resp_valid_o;
  logic              resp_ready_i;
  mc_req_s           net_req_o;
  logic              net_req_valid_o;
  logic              net_req_ready_i;
  mc_ret_s           net_ret_i;
  logic              net_ret_valid_i;
  logic              net_ret_ready_o;
  logic [CORD_W-1:0] my_x_i;
  logic [CORD_W-1:0] my_y_i;

  vec_s              vec_q[$];
  string             name_q[$];
  int                test_err[$];
  logic [ID_W-1:0]   req_id_q[$];
  int                ret_pend[$];
  int                cmd_idx;
  int                issue_cnt;
  int                resp_cnt;
  int                grp_start;
  int                errors;
  int                cycles;
  int                limit;
  logic              cmd_taken;

  mc_bridge_top i_mc_bridge_top (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .cmd_i           (cmd_i),
    .cmd_valid_i     (cmd_valid_i),
    .cmd_ready_o     (cmd_ready_o),
    .resp_o          (resp_o),
    .resp_valid_o    (resp_valid_o),
    .resp_ready_i    (resp_ready_i),
    .net_req_o       (net_req_o),
    .net_req_valid_o (net_req_valid_o),
    .net_req_ready_i (net_req_ready_i),
    .net_ret_i       (net_ret_i),
    .net_ret_valid_i (net_ret_valid_i),
    .net_ret_ready_o (net_ret_ready_o),
    .my_x_i          (my_x_i),
    .my_y_i          (my_y_i)
  );

  always #4 clk_i = ~clk_i;

  //////////////////////////////////////////////////
  // input file
  //////////////////////////////////////////////////
  task automatic load_vectors();
    int          fd;
    string       line;
    string       name;
    string       kind;
    int          size;
    int          grp;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] x;
    logic [31:0] y;
    logic [31:0] maddr;
    logic [31:0] mask;
    logic [31:0] ret;
    vec_s        v;
    fd = $fopen("tests/mc_bridge_input.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open tests/mc_bridge_input.txt");
      return;
    end
    while (!$feof(fd))
    begin
      line = "";
      if ($fgets(line, fd) > 0 && line.len() > 1 && line.getc(0) != "#")
      begin
        if ($sscanf(line, "%s %s %d %h %h %h %h %h %h %h %d", name, kind, size, addr,
                    data, x, y, maddr, mask, ret, grp) == 11)
        begin
          v                     = '0;
          v.cmd.header.msg_type = (kind == "wr") ? MSG_WR : MSG_RD;
          v.cmd.header.size     = (size == 1) ? SIZE_1 : (size == 2) ? SIZE_2 : SIZE_4;
          v.cmd.header.addr     = addr;
          v.cmd.data            = data;
          v.x                   = x[CORD_W-1:0];
          v.y                   = y[CORD_W-1:0];
          v.maddr               = maddr[MC_ADDR_W-1:0];
          v.mask                = mask[MASK_W-1:0];
          v.ret_data            = ret;
          v.group               = 8'(grp);
          vec_q.push_back(v);
          name_q.push_back(name);
          test_err.push_back(0);
        end
      end
    end
    $fclose(fd);
  endtask

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////
  task automatic check_field(input int idx, input string field, input logic [63:0] exp,
                             input logic [63:0] act);
    assert (act == exp)
    else
    begin
      $display("Fail %s %s: expected %0h, actual %0h", name_q[idx], field, exp, act);
      test_err[idx]++;
      errors++;
    end
  endtask

  task automatic check_request(input int idx);
    vec_s              v;
    load_info_s        li;
    mc_op_e            exp_op;
    logic [DATA_W-1:0] exp_payload;
    v = vec_q[idx];
    if (v.cmd.header.msg_type == MSG_WR)
    begin
      exp_op      = OP_STORE;
      exp_payload = v.cmd.data;
    end
    else
    begin
      // byte and half flags plus the byte lane
      li.is_byte  = (v.cmd.header.size == SIZE_1);
      li.is_half  = (v.cmd.header.size == SIZE_2);
      li.part_sel = v.cmd.header.addr[1:0];
      exp_op      = OP_LOAD;
      exp_payload = DATA_W'(li);
    end
    check_field(idx, "op", 64'(exp_op), 64'(net_req_o.op));
    check_field(idx, "x", 64'(v.x), 64'(net_req_o.x));
    check_field(idx, "y", 64'(v.y), 64'(net_req_o.y));
    check_field(idx, "mesh addr", 64'(v.maddr), 64'(net_req_o.addr));
    check_field(idx, "mask", 64'(v.mask), 64'(net_req_o.mask));
    check_field(idx, "payload", 64'(exp_payload), 64'(net_req_o.payload));
    // ids go round the buffer in issue order
    check_field(idx, "reg_id", 64'(idx % MAX_OUTSTANDING), 64'(net_req_o.reg_id));
    check_field(idx, "src_x", 64'(my_x_i), 64'(net_req_o.src_x));
    check_field(idx, "src_y", 64'(my_y_i), 64'(net_req_o.src_y));
  endtask

  task automatic check_response(input int idx);
    vec_s              v;
    logic [DATA_W-1:0] exp_data;
    v        = vec_q[idx];
    exp_data = (v.cmd.header.msg_type == MSG_RD) ? v.ret_data : '0;
    check_field(idx, "resp header", 64'(v.cmd.header), 64'(resp_o.header));
    check_field(idx, "resp data", 64'(exp_data), 64'(resp_o.data));
    if (test_err[idx] == 0)
    begin
      $display("done %s: ok", name_q[idx]);
    end
    else
    begin
      $display("done %s: %0d error(s)", name_q[idx], test_err[idx]);
    end
  endtask

  //////////////////////////////////////////////////
  // per-cycle drive and sample
  //////////////////////////////////////////////////
  task automatic drive_cycle();
    int grp_end;
    int idx;
    int i;
    if (cmd_taken)
    begin
      cmd_idx++;
      cmd_taken = 1'b0;
    end
    if (cmd_idx < vec_q.size())
    begin
      cmd_i       = vec_q[cmd_idx].cmd;
      cmd_valid_i = 1'b1;
    end
    else
    begin
      cmd_i       = '0;
      cmd_valid_i = 1'b0;
    end
    net_req_ready_i = ($urandom % 4) != 0;
    resp_ready_i    = ($urandom % 3) != 0;
    // mesh model returns a whole group in reverse once it is all out
    if (grp_start < vec_q.size())
    begin
      grp_end = grp_start;
      while (grp_end + 1 < vec_q.size() && vec_q[grp_end + 1].group == vec_q[grp_start].group)
      begin
        grp_end++;
      end
      if (issue_cnt > grp_end)
      begin
        for (i = grp_end; i >= grp_start; i--)
        begin
          ret_pend.push_back(i);
        end
        grp_start = grp_end + 1;
      end
    end
    if (ret_pend.size() > 0)
    begin
      idx              = ret_pend.pop_front();
      net_ret_i.reg_id = req_id_q[idx];
      net_ret_i.data   = vec_q[idx].ret_data;
      net_ret_valid_i  = 1'b1;
    end
    else
    begin
      net_ret_i       = '0;
      net_ret_valid_i = 1'b0;
    end
  endtask

  task automatic sample_cycle();
    if (cmd_valid_i && cmd_ready_o)
    begin
      cmd_taken = 1'b1;
    end
    if (net_req_valid_o && net_req_ready_i)
    begin
      if (issue_cnt < vec_q.size())
      begin
        check_request(issue_cnt);
        req_id_q.push_back(net_req_o.reg_id);
      end
      else
      begin
        $display("a mesh request was issued with no command left to match it");
        errors++;
      end
      issue_cnt++;
    end
    if (resp_valid_o && resp_ready_i)
    begin
      if (resp_cnt < vec_q.size())
      begin
        check_response(resp_cnt);
      end
      else
      begin
        $display("a response arrived with no command left to match it");
        errors++;
      end
      resp_cnt++;
    end
    assert (issue_cnt - resp_cnt <= MAX_OUTSTANDING)
    else
    begin
      $display("more than %0d requests are waiting for a response", MAX_OUTSTANDING);
      errors++;
    end
    assert (net_ret_ready_o)
    else
    begin
      $display("the bridge refused a mesh return");
      errors++;
    end
  endtask

  task automatic finish_run();
    int n_ok;
    int bound_fails;
    int i;
    n_ok = 0;
    for (i = 0; i < resp_cnt && i < test_err.size(); i++)
    begin
      if (test_err[i] == 0)
      begin
        n_ok++;
      end
    end
    bound_fails = i_mc_bridge_top.i_mc_bridge_asserts.resp_hold_fails +
                  i_mc_bridge_top.i_mc_bridge_asserts.in_flight_fails +
                  i_mc_bridge_top.i_mc_bridge_asserts.reset_fails;
    if (bound_fails > 0)
    begin
      $display("%0d bound handshake assertions fired", bound_fails);
      errors += bound_fails;
    end
    $display("summary: %0d tests, %0d answered, %0d ok, %0d failed checks",
             test_err.size(), resp_cnt, n_ok, errors);
    if (errors == 0)
    begin
      $display("test passed");
    end
    else
    begin
      $display("test failed");
    end
    $finish;
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////
  initial
  begin
    clk_i           = 1'b0;
    arst_n_i        = 1'b0;
    cmd_i           = '0;
    cmd_valid_i     = 1'b0;
    resp_ready_i    = 1'b0;
    net_req_ready_i = 1'b0;
    net_ret_i       = '0;
    net_ret_valid_i = 1'b0;
    my_x_i          = 4'd1;
    my_y_i          = 4'd3;
    cmd_idx         = 0;
    issue_cnt       = 0;
    resp_cnt        = 0;
    grp_start       = 0;
    errors          = 0;
    cycles          = 0;
    cmd_taken       = 1'b0;
    void'($urandom(32'h71a5db4b));
    load_vectors();
    // generous budget per command line
    limit = 200 * vec_q.size();
    repeat (4) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    while (vec_q.size() > 0 && resp_cnt < vec_q.size() && cycles < limit)
    begin
      @(posedge clk_i);
      #1;
      drive_cycle();
      @(negedge clk_i);
      sample_cycle();
      cycles++;
    end
    if (vec_q.size() == 0)
    begin
      $display("no commands could be read from the input file");
      errors++;
    end
    else if (resp_cnt < vec_q.size())
    begin
      $display("timeout after %0d cycles with %0d of %0d responses",
               cycles, resp_cnt, vec_q.size());
      errors++;
    end
    finish_run();
  end

endmodule

// File: tests/mc_bridge_asserts.sv
`timescale 1ns/1ps

module mc_bridge_asserts
  import mc_bridge_pkg::*;
(
  input logic     clk_i,
  input logic     arst_n_i,
  input cmd_msg_s resp_i,
  input logic     resp_valid_i,
  input logic     resp_ready_i,
  input logic     req_valid_i,
  input logic     req_ready_i
);

  // failure counts that the testbench reads at the end of the run
  int resp_hold_fails = 0;
  int in_flight_fails = 0;
  int reset_fails     = 0;

  // requests sent minus responses taken
  logic [3:0] in_flight_r;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      in_flight_r <= '0;
    end
    else
    begin
      in_flight_r <= in_flight_r + 4'(req_valid_i && req_ready_i)
                     - 4'(resp_valid_i && resp_ready_i);
    end
  end

  //////////////////////////////////////////////////
  // handshake stability
  //////////////////////////////////////////////////
  a_resp_hold: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    resp_valid_i && !resp_ready_i |=> resp_valid_i && $stable(resp_i)
  )
  else
  begin
    resp_hold_fails++;
    $error("response valid dropped or payload changed before ready");
  end

  // the reorder buffer bounds the requests in flight
  a_in_flight: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    in_flight_r <= 4'(MAX_OUTSTANDING)
  )
  else
  begin
    in_flight_fails++;
    $error("more mesh requests in flight than reorder entries");
  end

  // nothing leaves the bridge while in reset
  a_reset_quiet: assert property (
    @(posedge clk_i) !arst_n_i |-> !resp_valid_i && !req_valid_i
  )
  else
  begin
    reset_fails++;
    $error("valid output high during reset");
  end

endmodule

bind mc_bridge_top mc_bridge_asserts i_mc_bridge_asserts (
  .clk_i        (clk_i),
  .arst_n_i     (arst_n_i),
  .resp_i       (resp_o),
  .resp_valid_i (resp_valid_o),
  .resp_ready_i (resp_ready_i),
  .req_valid_i  (net_req_valid_o),
  .req_ready_i  (net_req_ready_i)
);

// File: source/mc_bridge_top.sv
`timescale 1ns/1ps

module mc_bridge_top
  import mc_bridge_pkg::*;
(
  input  logic              clk_i,
  input  logic              arst_n_i,

  // processor commands
  input  cmd_msg_s          cmd_i,
  input  logic              cmd_valid_i,
  output logic              cmd_ready_o,

  // processor responses
  output cmd_msg_s          resp_o,
  output logic              resp_valid_o,
  input  logic              resp_ready_i,

  // mesh requests
  output mc_req_s           net_req_o,
  output logic              net_req_valid_o,
  input  logic              net_req_ready_i,

  // mesh returns
  input  mc_ret_s           net_ret_i,
  input  logic              net_ret_valid_i,
  output logic              net_ret_ready_o,

  input  logic [CORD_W-1:0] my_x_i,
  input  logic [CORD_W-1:0] my_y_i
);

  cmd_msg_s        head_cmd;
  logic            head_valid;
  logic            issue_ready;
  logic            issue;
  logic [ID_W-1:0] trans_id;
  logic            trans_id_valid;

  //////////////////////////////////////////////////
  // command queue
  //////////////////////////////////////////////////
  mc_bridge_cmd_fifo i_cmd_fifo (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .push_data_i  (cmd_i),
    .push_valid_i (cmd_valid_i),
    .push_ready_o (cmd_ready_o),
    .pop_data_o   (head_cmd),
    .pop_valid_o  (head_valid),
    .pop_ready_i  (issue_ready)
  );

  // pop, id allocation and request all fire together
  assign issue_ready     = trans_id_valid & net_req_ready_i;
  assign issue           = head_valid & issue_ready;
  assign net_req_valid_o = issue;

  mc_bridge_packet_build i_packet_build (
    .cmd_i  (head_cmd),
    .id_i   (trans_id),
    .my_x_i (my_x_i),
    .my_y_i (my_y_i),
    .pkt_o  (net_req_o)
  );

  //////////////////////////////////////////////////
  // in-order response path
  //////////////////////////////////////////////////
  mc_bridge_reorder i_reorder (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .alloc_i      (issue),
    .hdr_i        (head_cmd.header),
    .id_o         (trans_id),
    .id_valid_o   (trans_id_valid),
    .ret_i        (net_ret_i),
    .ret_valid_i  (net_ret_valid_i),
    .resp_o       (resp_o),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i)
  );

  // every return already owns a reorder slot
  assign net_ret_ready_o = 1'b1;

endmodule

// File: source/mc_bridge_reorder.sv
`timescale 1ns/1ps

module mc_bridge_reorder
  import mc_bridge_pkg::*;
(
  input  logic            clk_i,
  input  logic            arst_n_i,

  // id allocation on issue
  input  logic            alloc_i,
  input  cmd_header_s     hdr_i,
  output logic [ID_W-1:0] id_o,
  output logic            id_valid_o,

  // returns from the mesh, any order
  input  mc_ret_s         ret_i,
  input  logic            ret_valid_i,

  // responses to the processor, command order
  output cmd_msg_s        resp_o,
  output logic            resp_valid_o,
  input  logic            resp_ready_i
);

  cmd_header_s                hdr_mem  [MAX_OUTSTANDING];
  logic [DATA_W-1:0]          data_mem [MAX_OUTSTANDING];
  logic [MAX_OUTSTANDING-1:0] busy_r;
  logic [MAX_OUTSTANDING-1:0] filled_r;
  logic [ID_W-1:0]            alloc_ptr_r;
  logic [ID_W-1:0]            rel_ptr_r;
  logic                       do_alloc;
  logic                       do_release;
  cmd_header_s                rel_hdr;

  //////////////////////////////////////////////////
  // allocation side
  //////////////////////////////////////////////////
  assign id_o       = alloc_ptr_r;
  assign id_valid_o = ~busy_r[alloc_ptr_r];
  assign do_alloc   = alloc_i & id_valid_o;

  //////////////////////////////////////////////////
  // release side
  //////////////////////////////////////////////////
  assign rel_hdr       = hdr_mem[rel_ptr_r];
  assign resp_valid_o  = filled_r[rel_ptr_r];
  assign do_release    = resp_valid_o & resp_ready_i;
  assign resp_o.header = rel_hdr;
  // a store completion carries no data back
  assign resp_o.data   = (rel_hdr.msg_type == MSG_RD) ? data_mem[rel_ptr_r] : '0;

  // payload storage
  always_ff @(posedge clk_i)
  begin
    if (do_alloc)
    begin
      hdr_mem[alloc_ptr_r] <= hdr_i;
    end
    if (ret_valid_i)
    begin
      data_mem[ret_i.reg_id] <= ret_i.data;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      busy_r      <= '0;
      filled_r    <= '0;
      alloc_ptr_r <= '0;
      rel_ptr_r   <= '0;
    end
    else
    begin
      // released, allocated and returned entries are always distinct
      if (do_release)
      begin
        busy_r[rel_ptr_r]   <= 1'b0;
        filled_r[rel_ptr_r] <= 1'b0;
        rel_ptr_r           <= rel_ptr_r + 1'b1;
      end
      if (do_alloc)
      begin
        busy_r[alloc_ptr_r]   <= 1'b1;
        filled_r[alloc_ptr_r] <= 1'b0;
        alloc_ptr_r           <= alloc_ptr_r + 1'b1;
      end
      if (ret_valid_i)
      begin
        filled_r[ret_i.reg_id] <= 1'b1;
      end
    end
  end

endmodule

// File: source/mc_bridge_packet_build.sv
`timescale 1ns/1ps

module mc_bridge_packet_build
  import mc_bridge_pkg::*;
(
  input  cmd_msg_s          cmd_i,
  input  logic [ID_W-1:0]   id_i,
  input  logic [CORD_W-1:0] my_x_i,
  input  logic [CORD_W-1:0] my_y_i,
  output mc_req_s           pkt_o
);

  logic [CORD_W-1:0]    dst_x;
  logic [CORD_W-1:0]    dst_y;
  logic [MC_ADDR_W-1:0] dst_addr;
  logic [1:0]           byte_off;
  logic [MASK_W-1:0]    store_mask;
  load_info_s           load_info;

  mc_bridge_addr_xlate i_addr_xlate (
    .addr_i    (cmd_i.header.addr),
    .x_o       (dst_x),
    .y_o       (dst_y),
    .mc_addr_o (dst_addr)
  );

  assign byte_off = cmd_i.header.addr[1:0];

  always_comb
  begin
    case (cmd_i.header.size)
      SIZE_1:  store_mask = MASK_W'(1) << byte_off;
      SIZE_2:  store_mask = MASK_W'(3) << byte_off;
      default: store_mask = '1 << byte_off;
    endcase
  end

  assign load_info.is_byte  = (cmd_i.header.size == SIZE_1);
  assign load_info.is_half  = (cmd_i.header.size == SIZE_2);
  assign load_info.part_sel = byte_off;

  always_comb
  begin
    pkt_o        = '0;
    pkt_o.x      = dst_x;
    pkt_o.y      = dst_y;
    pkt_o.addr   = dst_addr;
    pkt_o.reg_id = id_i;
    pkt_o.src_x  = my_x_i;
    pkt_o.src_y  = my_y_i;
    if (cmd_i.header.msg_type == MSG_WR)
    begin
      pkt_o.op      = OP_STORE;
      pkt_o.mask    = store_mask;
      pkt_o.payload = cmd_i.data;
    end
    else
    begin
      // loads carry no mask
      pkt_o.op      = OP_LOAD;
      pkt_o.payload = DATA_W'(load_info);
    end
  end

endmodule

// File: source/mc_bridge_addr_xlate.sv
`timescale 1ns/1ps

module mc_bridge_addr_xlate
  import mc_bridge_pkg::*;
(
  input  logic [ADDR_W-1:0]    addr_i,
  output logic [CORD_W-1:0]    x_o,
  output logic [CORD_W-1:0]    y_o,
  output logic [MC_ADDR_W-1:0] mc_addr_o
);

  logic                     is_dram;
  logic [HASH_IN_W-1:0]     hash_in;
  logic [BANK_W-1:0]        bank;
  logic [BANK_INDEX_W-1:0]  bank_index;
  logic [WORD_OFF_W-1:0]    word_off;
  logic [CORD_W-1:0]        tile_x;
  logic [CORD_W-1:0]        tile_y;
  logic [MC_ADDR_W-1:0]     tile_addr;
  logic [CORD_W-1:0]        dram_x;
  logic [CORD_W-1:0]        dram_y;
  logic [MC_ADDR_W-1:0]     dram_addr;

  assign is_dram = addr_i[DRAM_FLAG_BIT];

  //////////////////////////////////////////////////
  // tile space
  //////////////////////////////////////////////////
  // word address at the bottom, then x, then y
  assign tile_addr = addr_i[2 +: MC_ADDR_W];
  assign tile_x    = addr_i[2 + MC_ADDR_W +: CORD_W];
  assign tile_y    = addr_i[2 + MC_ADDR_W + CORD_W +: CORD_W];

  //////////////////////////////////////////////////
  // dram space
  //////////////////////////////////////////////////
  // block-interleaved over the banks
  assign word_off   = addr_i[2 +: WORD_OFF_W];
  assign hash_in    = addr_i[2 + WORD_OFF_W +: HASH_IN_W];
  assign bank       = BANK_W'(hash_in % NUM_BANKS);
  assign bank_index = BANK_INDEX_W'(hash_in / NUM_BANKS);

  assign dram_x = CORD_W'(bank[X_SUB_W-1:0]);
  // upper half of the banks live just below the tile array
  assign dram_y = bank[BANK_W-1] ? CORD_W'(TILES_Y + 1) : '0;
  assign dram_addr = MC_ADDR_W'({bank_index, word_off});

  always_comb
  begin
    if (is_dram)
    begin
      x_o       = dram_x;
      y_o       = dram_y;
      mc_addr_o = dram_addr;
    end
    else
    begin
      x_o       = tile_x;
      y_o       = tile_y;
      mc_addr_o = tile_addr;
    end
  end

endmodule

// File: source/mc_bridge_cmd_fifo.sv
`timescale 1ns/1ps

module mc_bridge_cmd_fifo
  import mc_bridge_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,

  input  cmd_msg_s push_data_i,
  input  logic     push_valid_i,
  output logic     push_ready_o,

  output cmd_msg_s pop_data_o,
  output logic     pop_valid_o,
  input  logic     pop_ready_i
);

  cmd_msg_s              mem [CMD_FIFO_DEPTH];
  logic [CMD_PTR_W-1:0]  wr_ptr_r;
  logic [CMD_PTR_W-1:0]  rd_ptr_r;
  logic [CMD_CNT_W-1:0]  count_r;
  logic                  push;
  logic                  pop;
  logic                  full;

  assign full         = (count_r == CMD_CNT_W'(CMD_FIFO_DEPTH));
  assign pop_valid_o  = (count_r != '0);
  // a pop frees a slot in the same cycle
  assign push_ready_o = ~full | pop_ready_i;
  assign push         = push_valid_i & push_ready_o;
  assign pop          = pop_valid_o & pop_ready_i;
  assign pop_data_o   = mem[rd_ptr_r];

  always_ff @(posedge clk_i)
  begin
    if (push)
    begin
      mem[wr_ptr_r] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr_r <= (wr_ptr_r == CMD_PTR_W'(CMD_FIFO_DEPTH - 1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (pop)
      begin
        rd_ptr_r <= (rd_ptr_r == CMD_PTR_W'(CMD_FIFO_DEPTH - 1)) ? '0 : rd_ptr_r + 1'b1;
      end
      // count only moves when exactly one side fires
      if (push && !pop)
      begin
        count_r <= count_r + 1'b1;
      end
      else if (pop && !push)
      begin
        count_r <= count_r - 1'b1;
      end
    end
  end

endmodule

// File: source/mc_bridge_pkg.sv
package mc_bridge_pkg;

  //////////////////////////////////////////////////
  // sizes
  //////////////////////////////////////////////////
  localparam int ADDR_W          = 32;
  localparam int DATA_W          = 32;
  localparam int MASK_W          = DATA_W / 8;
  localparam int MAX_OUTSTANDING = 4;
  localparam int ID_W            = $clog2(MAX_OUTSTANDING);
  localparam int CMD_FIFO_DEPTH  = 2;
  localparam int CMD_PTR_W       = $clog2(CMD_FIFO_DEPTH);
  localparam int CMD_CNT_W       = $clog2(CMD_FIFO_DEPTH + 1);

  // mesh geometry
  localparam int CORD_W    = 4;
  localparam int MC_ADDR_W = 16;
  localparam int TILES_X   = 4;
  localparam int TILES_Y   = 4;
  localparam int X_SUB_W   = $clog2(TILES_X);

  // dram banks sit on the top and bottom rows, two per column
  localparam int NUM_BANKS     = 2 * TILES_X;
  localparam int BANK_W        = $clog2(NUM_BANKS);
  localparam int BLOCK_WORDS   = 4;
  localparam int WORD_OFF_W    = $clog2(BLOCK_WORDS);
  localparam int BANK_INDEX_W  = 6;
  localparam int DRAM_FLAG_BIT = 31;
  // address bits between the byte offset and the dram flag
  localparam int HASH_IN_W     = ADDR_W - 1 - 2 - WORD_OFF_W;

  //////////////////////////////////////////////////
  // opcodes
  //////////////////////////////////////////////////
  typedef enum logic {
    MSG_RD = 1'b0,
    MSG_WR = 1'b1
  } msg_type_e;

  typedef enum logic [1:0] {
    SIZE_1 = 2'b00,
    SIZE_2 = 2'b01,
    SIZE_4 = 2'b10
  } msg_size_e;

  typedef enum logic {
    OP_LOAD  = 1'b0,
    OP_STORE = 1'b1
  } mc_op_e;

  //////////////////////////////////////////////////
  // processor side messages
  //////////////////////////////////////////////////
  typedef struct packed {
    msg_type_e          msg_type;
    msg_size_e          size;
    logic [ADDR_W-1:0]  addr;
  } cmd_header_s;

  // commands and responses share this layout
  typedef struct packed {
    cmd_header_s        header;
    logic [DATA_W-1:0]  data;
  } cmd_msg_s;

  //////////////////////////////////////////////////
  // mesh side packets
  //////////////////////////////////////////////////
  typedef struct packed {
    logic       is_byte;
    logic       is_half;
    logic [1:0] part_sel;
  } load_info_s;

  typedef struct packed {
    mc_op_e               op;
    logic [CORD_W-1:0]    x;
    logic [CORD_W-1:0]    y;
    logic [MC_ADDR_W-1:0] addr;
    logic [ID_W-1:0]      reg_id;
    logic [MASK_W-1:0]    mask;
    // store data, or load_info_s in the low bits for loads
    logic [DATA_W-1:0]    payload;
    logic [CORD_W-1:0]    src_x;
    logic [CORD_W-1:0]    src_y;
  } mc_req_s;

  typedef struct packed {
    logic [ID_W-1:0]   reg_id;
    logic [DATA_W-1:0] data;
  } mc_ret_s;

endpackage
